/* flist.f */
source/bus_pkg.sv
source/sitcp_pkg.sv
source/tcp_frame_decoder.sv
source/rbcp_access.sv
source/bus_arbiter.sv
source/bus_register_bank.sv
source/sitcp_bus_bridge_top.sv
sim/tb_clock_gen.sv
sim/tb_sitcp_bus_bridge.sv

/* run_sim.sh */
#!/bin/sh
# Builds the bridge testbench with Verilator, runs it and scans the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --timescale 1ns/10ps -f flist.f \
    --top-module tb_sitcp_bus_bridge -o tb_sitcp_bus_bridge > "$LOG" 2>&1 \
    && ./obj_dir/tb_sitcp_bus_bridge >> "$LOG" 2>&1 \
    || echo "SIMULATION FAILED" >> "$LOG"

cat "$LOG"

grep -q "SIMULATION FAILED" "$LOG" && exit 1 || exit 0

/* sim/sitcp_bridge_trace.txt */
# Fields in hex. W addr data during_next_T | R addr expected | V expected INVALID
# T length addr bytes_sent first_byte random_gaps | X resync run | C TCP_RX_WC of last burst
W 00000010 a5 0
R 00000010 a5
W 00000000 99 0
W 00000001 98 0
W 00000100 5a 0
R 00000100 00
T 0010 00000040 0010 30 0
C 0016
R 00000040 30
R 0000004f 3f
T 0008 00000060 0008 c0 1
R 00000067 c7
T fffa 00000010 0004 11 0
V 1
R 00000010 a5
X
V 0
C ffff
T 0004 fffffffe 0004 71 0
V 1
R 00000000 99
R 00000001 98
X
V 0
T 0004 00000020 0004 e0 1
R 00000020 e0
R 00000023 e3
W 00000008 3c 1
T 0064 00000080 0064 00 0
C 006a
R 00000008 3c
R 00000080 00
R 000000b2 32
R 000000e3 63

/* sim/tb_sitcp_bus_bridge.sv */
`timescale 1ns/10ps

module tb_sitcp_bus_bridge;

    localparam int ACK_TIMEOUT   = 1000;
    localparam int RESET_TIMEOUT = 16;
    localparam int GAP_MAX       = 3;

    logic                 BUS_CLK;
    logic                 BUS_RST;
    logic                 TCP_RX_WR;
    bus_pkg::bus_data_t   TCP_RX_DATA;
    sitcp_pkg::rx_count_t TCP_RX_WC;
    logic                 RBCP_ACT;
    bus_pkg::bus_addr_t   RBCP_ADDR;
    bus_pkg::bus_data_t   RBCP_WD;
    logic                 RBCP_WE;
    logic                 RBCP_RE;
    logic                 RBCP_ACK;
    bus_pkg::bus_data_t   RBCP_RD;
    logic                 INVALID;
    logic                 BUS_WR;
    logic                 BUS_RD;
    bus_pkg::bus_addr_t   BUS_ADD;
    bus_pkg::bus_data_t   bus_wdata;

    // TCP_RX_WC right after the last byte of the latest burst
    sitcp_pkg::rx_count_t burst_wc;

    // Set by a frame that breaks a header rule, cleared by the resync pattern
    logic                 frame_flagged;

    tb_clock_gen tb_clock_gen_i (
        .BUS_CLK (BUS_CLK),
        .BUS_RST (BUS_RST)
    );

    sitcp_bus_bridge_top sitcp_bus_bridge_top_i (
        .BUS_CLK     (BUS_CLK),
        .BUS_RST     (BUS_RST),
        .TCP_RX_WR   (TCP_RX_WR),
        .TCP_RX_DATA (TCP_RX_DATA),
        .TCP_RX_WC   (TCP_RX_WC),
        .RBCP_ACT    (RBCP_ACT),
        .RBCP_ADDR   (RBCP_ADDR),
        .RBCP_WD     (RBCP_WD),
        .RBCP_WE     (RBCP_WE),
        .RBCP_RE     (RBCP_RE),
        .RBCP_ACK    (RBCP_ACK),
        .RBCP_RD     (RBCP_RD),
        .INVALID     (INVALID),
        .BUS_WR      (BUS_WR),
        .BUS_RD      (BUS_RD),
        .BUS_ADD     (BUS_ADD),
        .bus_wdata   (bus_wdata)
    );

    task automatic check_rd_data(input string name, input bus_pkg::bus_data_t expected,
                                 input bus_pkg::bus_data_t actual);
        if (actual !== expected) begin
            $display("FAIL %s expected %02h actual %02h", name, expected, actual);
            $display("SIMULATION FAILED");
            $fatal(1, "read data mismatch");
        end
    endtask

    task automatic check_invalid(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("FAIL %s expected %b actual %b", name, expected, actual);
            $display("SIMULATION FAILED");
            $fatal(1, "INVALID mismatch");
        end
    endtask

    task automatic check_rx_wc(input string name, input sitcp_pkg::rx_count_t expected,
                               input sitcp_pkg::rx_count_t actual);
        if (actual !== expected) begin
            $display("FAIL %s expected %04h actual %04h", name, expected, actual);
            $display("SIMULATION FAILED");
            $fatal(1, "TCP_RX_WC mismatch");
        end
    endtask

    // Strobes always, address and data only when a write is expected
    task automatic check_bus_req(input string name, input bus_pkg::bus_req_t expected,
                                 input bus_pkg::bus_req_t actual);
        if (actual.wr !== expected.wr || actual.rd !== expected.rd
            || (expected.wr && (actual.addr !== expected.addr
                                || actual.wdata !== expected.wdata))) begin
            $display("FAIL %s expected %b %b %08h %02h actual %b %b %08h %02h", name,
                     expected.wr, expected.rd, expected.addr, expected.wdata,
                     actual.wr, actual.rd, actual.addr, actual.wdata);
            $display("SIMULATION FAILED");
            $fatal(1, "bus cycle mismatch");
        end
    endtask

    // Local bus outputs gathered into one request
    function automatic bus_pkg::bus_req_t observed_bus();
        bus_pkg::bus_req_t req;
        req.wr    = BUS_WR;
        req.rd    = BUS_RD;
        req.addr  = BUS_ADD;
        req.wdata = bus_wdata;
        return req;
    endfunction

    // Every task starts and ends 1 ns after a rising edge
    task automatic wait_cycles(input int n);
        for (int i = 0; i < n; i++) begin
            @(posedge BUS_CLK);
            #1;
        end
    endtask

    task automatic send_byte(input bus_pkg::bus_data_t value);
        TCP_RX_WR   = 1'b1;
        TCP_RX_DATA = value;
        wait_cycles(1);
    endtask

    // Header bytes little endian, payload counts up from first
    task automatic send_frame(input sitcp_pkg::rx_count_t len, input bus_pkg::bus_addr_t addr,
                              input int count, input bus_pkg::bus_data_t first,
                              input logic gaps);
        bus_pkg::bus_data_t bytes[$];
        int                 idle;
        logic               write_ok;
        bus_pkg::bus_req_t  expected;
        bytes.push_back(len[7:0]);
        bytes.push_back(len[15:8]);
        bytes.push_back(addr[7:0]);
        bytes.push_back(addr[15:8]);
        bytes.push_back(addr[23:16]);
        bytes.push_back(addr[31:24]);
        for (int i = 0; i < count; i++) begin
            bytes.push_back(first + bus_pkg::bus_data_t'(i));
        end
        // Payload reaches the bus only for a frame within both header limits
        write_ok = !frame_flagged && len <= sitcp_pkg::MAX_LENGTH
                   && (64'(addr) + 64'(len)) <= 64'h1_0000_0000;
        if (!write_ok) begin
            frame_flagged = 1'b1;
        end
        foreach (bytes[i]) begin
            if (gaps && i > 0) begin
                idle      = int'($urandom_range(GAP_MAX, 0));
                TCP_RX_WR = 1'b0;
                wait_cycles(idle);
            end
            send_byte(bytes[i]);
            // Each payload byte shows on the bus one cycle after it is taken
            if (i >= sitcp_pkg::HEADER_BYTES) begin
                expected.wr    = write_ok;
                expected.rd    = 1'b0;
                expected.addr  = addr + bus_pkg::bus_addr_t'(i - sitcp_pkg::HEADER_BYTES);
                expected.wdata = bytes[i];
                check_bus_req($sformatf("frame byte at %08h", expected.addr), expected,
                              observed_bus());
            end
        end
        burst_wc  = TCP_RX_WC;
        TCP_RX_WR = 1'b0;
    endtask

    task automatic send_resync();
        for (int i = 0; i < int'(sitcp_pkg::RESYNC_COUNT); i++) begin
            send_byte(8'hFF);
        end
        burst_wc      = TCP_RX_WC;
        TCP_RX_WR     = 1'b0;
        frame_flagged = 1'b0;
    endtask

    // One RBCP access, WE or RE for a single cycle, ACT until ACK
    task automatic rbcp_cycle(input logic write, input bus_pkg::bus_addr_t addr,
                              input bus_pkg::bus_data_t wd);
        int waited;
        RBCP_ACT  = 1'b1;
        RBCP_WE   = write;
        RBCP_RE   = !write;
        RBCP_ADDR = addr;
        RBCP_WD   = wd;
        waited    = 0;
        do begin
            wait_cycles(1);
            RBCP_WE = 1'b0;
            RBCP_RE = 1'b0;
            waited++;
        end while (!RBCP_ACK && waited < ACK_TIMEOUT);
        RBCP_ACT = 1'b0;
        if (!RBCP_ACK) begin
            $display("RBCP access to %08h got no ACK within %0d cycles", addr, ACK_TIMEOUT);
            $display("SIMULATION FAILED");
            $fatal(1, "RBCP timeout");
        end
        // Idle cycle so the next request is not lost behind the ACK
        wait_cycles(1);
    endtask

    initial begin
        int                 fd;
        int                 fields;
        int                 line_no;
        int                 waited;
        string              line;
        string              name;
        logic [7:0]         cmd;
        logic [31:0]        a;
        logic [31:0]        b;
        logic [31:0]        c;
        logic [31:0]        d;
        logic [31:0]        e;
        logic               held_wr;
        bus_pkg::bus_addr_t held_addr;
        bus_pkg::bus_data_t held_data;

        void'($urandom(32'hdd67));
        TCP_RX_WR     = 1'b0;
        TCP_RX_DATA   = '0;
        RBCP_ACT      = 1'b0;
        RBCP_WE       = 1'b0;
        RBCP_RE       = 1'b0;
        RBCP_ADDR     = '0;
        RBCP_WD       = '0;
        burst_wc      = '0;
        frame_flagged = 1'b0;
        held_wr       = 1'b0;
        held_addr     = '0;
        held_data     = '0;

        waited = 0;
        do begin
            @(negedge BUS_CLK);
            waited++;
        end while (BUS_RST !== 1'b0 && waited < RESET_TIMEOUT);
        if (BUS_RST !== 1'b0) begin
            $display("BUS_RST was never released");
            $display("SIMULATION FAILED");
            $fatal(1, "reset timeout");
        end
        wait_cycles(1);
        check_invalid("after reset", 1'b0, INVALID);
        check_rx_wc("after reset", 16'h0000, TCP_RX_WC);
        check_bus_req("after reset", '0, observed_bus());

        fd = $fopen("sim/sitcp_bridge_trace.txt", "r");
        if (fd == 0) begin
            $display("Could not open sim/sitcp_bridge_trace.txt");
            $display("SIMULATION FAILED");
            $fatal(1, "missing trace");
        end
        line_no = 0;
        while ($fgets(line, fd) != 0) begin
            line_no++;
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;
            end
            fields = $sscanf(line, "%c %h %h %h %h %h", cmd, a, b, c, d, e);
            name   = $sformatf("trace line %0d (%c)", line_no, cmd);
            case (cmd)
                "W": begin
                    if (fields > 3 && c[0]) begin
                        // Issued in the middle of the next TCP frame
                        held_wr   = 1'b1;
                        held_addr = a;
                        held_data = b[7:0];
                    end else begin
                        rbcp_cycle(1'b1, a, b[7:0]);
                    end
                end
                "R": begin
                    rbcp_cycle(1'b0, a, 8'h00);
                    check_rd_data(name, b[7:0], RBCP_RD);
                end
                "T": begin
                    if (held_wr) begin
                        fork
                            send_frame(a[15:0], b, int'(c), d[7:0], e[0]);
                            begin
                                wait_cycles(sitcp_pkg::HEADER_BYTES + int'(c) / 2);
                                rbcp_cycle(1'b1, held_addr, held_data);
                            end
                        join
                        held_wr = 1'b0;
                    end else begin
                        send_frame(a[15:0], b, int'(c), d[7:0], e[0]);
                    end
                end
                "X": send_resync();
                "V": check_invalid(name, a[0], INVALID);
                "C": check_rx_wc(name, a[15:0], burst_wc);
                default: begin
                    $display("Unknown command in trace line %0d", line_no);
                    $display("SIMULATION FAILED");
                    $fatal(1, "bad trace");
                end
            endcase
        end
        $fclose(fd);

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

/* sim/tb_clock_gen.sv */
`timescale 1ns/10ps

module tb_clock_gen (
    output logic BUS_CLK,
    output logic BUS_RST
);

    // 4 ns period
    initial begin
        BUS_CLK = 1'b0;
        forever begin
            #2;
            BUS_CLK = ~BUS_CLK;
        end
    end

    // Reset seen by the first two rising edges
    initial begin
        BUS_RST = 1'b1;
        repeat (2) begin
            @(posedge BUS_CLK);
        end
        #1;
        BUS_RST = 1'b0;
    end

endmodule

/* source/sitcp_bus_bridge_top.sv */
`timescale 1ns/10ps

module sitcp_bus_bridge_top (
    input  logic                 BUS_CLK,
    input  logic                 BUS_RST,

    // SiTCP TCP receive
    input  logic                 TCP_RX_WR,
    input  bus_pkg::bus_data_t   TCP_RX_DATA,
    output sitcp_pkg::rx_count_t TCP_RX_WC,

    // SiTCP RBCP
    input  logic                 RBCP_ACT,
    input  bus_pkg::bus_addr_t   RBCP_ADDR,
    input  bus_pkg::bus_data_t   RBCP_WD,
    input  logic                 RBCP_WE,
    input  logic                 RBCP_RE,
    output logic                 RBCP_ACK,
    output bus_pkg::bus_data_t   RBCP_RD,

    output logic                 INVALID,

    // Local bus, visible for observation
    output logic                 BUS_WR,
    output logic                 BUS_RD,
    output bus_pkg::bus_addr_t   BUS_ADD,
    output bus_pkg::bus_data_t   bus_wdata
);

    sitcp_pkg::rbcp_req_t rbcp_pins;
    bus_pkg::bus_req_t    tcp_req;
    bus_pkg::bus_req_t    rbcp_req;
    bus_pkg::bus_req_t    bus_req;
    logic                 rbcp_grant;
    bus_pkg::bus_data_t   bus_rdata;

    assign rbcp_pins = '{act: RBCP_ACT, we: RBCP_WE, re: RBCP_RE,
                         addr: RBCP_ADDR, wd: RBCP_WD};

    tcp_frame_decoder tcp_frame_decoder_i (
        .BUS_CLK (BUS_CLK),
        .BUS_RST (BUS_RST),
        .rx_wr   (TCP_RX_WR),
        .rx_data (TCP_RX_DATA),
        .rx_wc   (TCP_RX_WC),
        .invalid (INVALID),
        .tcp_req (tcp_req)
    );

    rbcp_access rbcp_access_i (
        .BUS_CLK    (BUS_CLK),
        .BUS_RST    (BUS_RST),
        .rbcp       (rbcp_pins),
        .rbcp_grant (rbcp_grant),
        .bus_rdata  (bus_rdata),
        .rbcp_req   (rbcp_req),
        .rbcp_ack   (RBCP_ACK),
        .rbcp_rd    (RBCP_RD)
    );

    bus_arbiter bus_arbiter_i (
        .tcp_req    (tcp_req),
        .rbcp_req   (rbcp_req),
        .bus_req    (bus_req),
        .rbcp_grant (rbcp_grant)
    );

    bus_register_bank bus_register_bank_i (
        .BUS_CLK (BUS_CLK),
        .BUS_RST (BUS_RST),
        .bus_req (bus_req),
        .rdata   (bus_rdata)
    );

    assign BUS_WR    = bus_req.wr;
    assign BUS_RD    = bus_req.rd;
    assign BUS_ADD   = bus_req.addr;
    assign bus_wdata = bus_req.wdata;

endmodule

/* source/bus_register_bank.sv */
`timescale 1ns/10ps

module bus_register_bank (
    input  logic               BUS_CLK,
    input  logic               BUS_RST,
    input  bus_pkg::bus_req_t  bus_req,
    output bus_pkg::bus_data_t rdata
);

    bus_pkg::bus_data_t                     mem [bus_pkg::BANK_DEPTH];
    logic                                   in_range;
    logic [bus_pkg::BANK_ADDR_W-1:0]        idx;

    assign in_range = bus_req.addr < bus_pkg::bus_addr_t'(bus_pkg::BANK_DEPTH);
    assign idx      = bus_req.addr[bus_pkg::BANK_ADDR_W-1:0];

    always_ff @(posedge BUS_CLK) begin
        if (BUS_RST) begin
            for (int i = 0; i < bus_pkg::BANK_DEPTH; i++) begin
                mem[i] <= '0;
            end
            rdata <= '0;
        end else begin
            if (bus_req.wr && in_range) begin
                mem[idx] <= bus_req.wdata;
            end
            // Reads outside the bank return zero
            if (bus_req.rd) begin
                rdata <= in_range ? mem[idx] : '0;
            end
        end
    end

endmodule

/* source/bus_arbiter.sv */
`timescale 1ns/10ps

module bus_arbiter (
    input  bus_pkg::bus_req_t tcp_req,
    input  bus_pkg::bus_req_t rbcp_req,
    output bus_pkg::bus_req_t bus_req,
    output logic              rbcp_grant
);

    logic rbcp_active;

    assign rbcp_active = rbcp_req.wr | rbcp_req.rd;

    // TCP has no back-pressure, so its writes always take the bus.
    // An RBCP request simply waits in rbcp_access until a free cycle.
    always_comb begin
        if (tcp_req.wr) begin
            bus_req    = tcp_req;
            rbcp_grant = 1'b0;
        end else begin
            bus_req    = rbcp_req;
            rbcp_grant = rbcp_active;
        end
    end

endmodule

/* source/rbcp_access.sv */
`timescale 1ns/10ps

module rbcp_access (
    input  logic                BUS_CLK,
    input  logic                BUS_RST,
    input  sitcp_pkg::rbcp_req_t rbcp,
    input  logic                rbcp_grant,
    input  bus_pkg::bus_data_t  bus_rdata,
    output bus_pkg::bus_req_t   rbcp_req,
    output logic                rbcp_ack,
    output bus_pkg::bus_data_t  rbcp_rd
);

    logic               pend_wr;
    logic               pend_rd;
    logic               rd_wait;
    logic               busy;
    bus_pkg::bus_addr_t addr_q;
    bus_pkg::bus_data_t wd_q;

    // Nothing new is taken until the previous access has been acknowledged
    assign busy = pend_wr | pend_rd | rd_wait | rbcp_ack;

    always_ff @(posedge BUS_CLK) begin
        if (BUS_RST) begin
            pend_wr  <= 1'b0;
            pend_rd  <= 1'b0;
            rd_wait  <= 1'b0;
            rbcp_ack <= 1'b0;
        end else begin
            rbcp_ack <= 1'b0;
            rd_wait  <= 1'b0;
            if (!busy && rbcp.act && (rbcp.we || rbcp.re)) begin
                // Write wins if both strobes arrive together
                pend_wr <= rbcp.we;
                pend_rd <= rbcp.re & ~rbcp.we;
            end else if (rbcp_grant) begin
                pend_wr <= 1'b0;
                pend_rd <= 1'b0;
                rbcp_ack <= pend_wr;
                rd_wait  <= pend_rd;
            end
            // Bank data is valid the cycle after the read strobe
            if (rd_wait) begin
                rbcp_ack <= 1'b1;
            end
        end
    end

    always_ff @(posedge BUS_CLK) begin
        if (!busy && rbcp.act) begin
            addr_q <= rbcp.addr;
            wd_q   <= rbcp.wd;
        end
        if (rd_wait) begin
            rbcp_rd <= bus_rdata;
        end
    end

    always_comb begin
        rbcp_req.wr    = pend_wr;
        rbcp_req.rd    = pend_rd;
        rbcp_req.addr  = addr_q;
        rbcp_req.wdata = wd_q;
    end

endmodule

/* source/tcp_frame_decoder.sv */
`timescale 1ns/10ps

module tcp_frame_decoder (
    input  logic                 BUS_CLK,
    input  logic                 BUS_RST,
    input  logic                 rx_wr,
    input  bus_pkg::bus_data_t   rx_data,
    output sitcp_pkg::rx_count_t rx_wc,
    output logic                 invalid,
    output bus_pkg::bus_req_t    tcp_req
);

    sitcp_pkg::dec_state_t state;
    sitcp_pkg::rx_count_t  length;
    sitcp_pkg::rx_count_t  remaining;
    sitcp_pkg::rx_count_t  ff_cnt;
    bus_pkg::bus_addr_t    next_addr;
    bus_pkg::bus_addr_t    start_addr;
    logic [32:0]           frame_end;
    logic                  len_bad;
    logic                  addr_bad;
    logic                  resync;

    logic                  wr_q;
    bus_pkg::bus_addr_t    addr_q;
    bus_pkg::bus_data_t    wdata_q;

    // Header checks, evaluated on the byte that completes each field
    assign len_bad    = {rx_data, length[7:0]} > sitcp_pkg::MAX_LENGTH;
    assign start_addr = {rx_data, next_addr[23:0]};
    assign frame_end  = {1'b0, start_addr} + {17'd0, length};
    assign addr_bad   = frame_end > 33'h1_0000_0000;

    // Last byte of the 0xFF run
    assign resync = rx_wr && (rx_data == 8'hFF)
                    && (ff_cnt == sitcp_pkg::RESYNC_COUNT - 16'd1);

    // Receive write count, cleared by the first idle cycle
    always_ff @(posedge BUS_CLK) begin
        if (BUS_RST) begin
            rx_wc <= '0;
        end else if (rx_wr) begin
            rx_wc <= rx_wc + 16'd1;
        end else begin
            rx_wc <= '0;
        end
    end

    // Counts consecutive 0xFF bytes, saturating one short of the pattern
    always_ff @(posedge BUS_CLK) begin
        if (BUS_RST) begin
            ff_cnt <= '0;
        end else if (rx_wr) begin
            if (rx_data != 8'hFF) begin
                ff_cnt <= '0;
            end else if (ff_cnt != sitcp_pkg::RESYNC_COUNT - 16'd1) begin
                ff_cnt <= ff_cnt + 16'd1;
            end
        end
    end

    always_ff @(posedge BUS_CLK) begin
        if (BUS_RST) begin
            state     <= sitcp_pkg::LEN_LO;
            invalid   <= 1'b0;
            length    <= '0;
            remaining <= '0;
            next_addr <= '0;
        end else if (resync) begin
            state   <= sitcp_pkg::LEN_LO;
            invalid <= 1'b0;
        end else if (rx_wr) begin
            case (state)
                sitcp_pkg::LEN_LO: begin
                    length[7:0] <= rx_data;
                    state       <= sitcp_pkg::LEN_HI;
                end
                sitcp_pkg::LEN_HI: begin
                    length[15:8] <= rx_data;
                    if (len_bad) begin
                        invalid <= 1'b1;
                    end
                    state <= sitcp_pkg::ADDR0;
                end
                sitcp_pkg::ADDR0: begin
                    next_addr[7:0] <= rx_data;
                    state          <= sitcp_pkg::ADDR1;
                end
                sitcp_pkg::ADDR1: begin
                    next_addr[15:8] <= rx_data;
                    state           <= sitcp_pkg::ADDR2;
                end
                sitcp_pkg::ADDR2: begin
                    next_addr[23:16] <= rx_data;
                    state            <= sitcp_pkg::ADDR3;
                end
                sitcp_pkg::ADDR3: begin
                    next_addr[31:24] <= rx_data;
                    remaining        <= length;
                    if (addr_bad) begin
                        invalid <= 1'b1;
                    end
                    // A flagged decoder drops every frame until resync
                    if (length == '0) begin
                        state <= sitcp_pkg::LEN_LO;
                    end else if (invalid || addr_bad) begin
                        state <= sitcp_pkg::DROP;
                    end else begin
                        state <= sitcp_pkg::PAYLOAD;
                    end
                end
                sitcp_pkg::PAYLOAD: begin
                    next_addr <= next_addr + 32'd1;
                    remaining <= remaining - 16'd1;
                    if (remaining == 16'd1) begin
                        state <= sitcp_pkg::LEN_LO;
                    end
                end
                default: begin
                    // DROP keeps frame alignment without touching the bus
                    remaining <= remaining - 16'd1;
                    if (remaining == 16'd1) begin
                        state <= sitcp_pkg::LEN_LO;
                    end
                end
            endcase
        end
    end

    // One register stage for strobe, address and data alike
    always_ff @(posedge BUS_CLK) begin
        if (BUS_RST) begin
            wr_q <= 1'b0;
        end else begin
            wr_q <= rx_wr && (state == sitcp_pkg::PAYLOAD) && !resync;
        end
    end

    always_ff @(posedge BUS_CLK) begin
        addr_q  <= next_addr;
        wdata_q <= rx_data;
    end

    always_comb begin
        tcp_req.wr    = wr_q;
        tcp_req.rd    = 1'b0;
        tcp_req.addr  = addr_q;
        tcp_req.wdata = wdata_q;
    end

endmodule

/* source/sitcp_pkg.sv */
package sitcp_pkg;

    // Receive write count and frame length share one width
    typedef logic [15:0] rx_count_t;

    // Frame header is 2 length bytes plus 4 address bytes
    localparam int HEADER_BYTES = 6;

    // Largest payload that still fits in a 16-bit frame with its header
    localparam rx_count_t MAX_LENGTH = rx_count_t'(65535 - HEADER_BYTES);

    // Consecutive 0xFF bytes that force the decoder back to a frame start
    localparam rx_count_t RESYNC_COUNT = 16'hFFFF;

    // Frame decoder states, one per header byte plus the two payload modes
    typedef enum logic [2:0] {
        LEN_LO,
        LEN_HI,
        ADDR0,
        ADDR1,
        ADDR2,
        ADDR3,
        PAYLOAD,
        DROP
    } dec_state_t;

    // RBCP pins as delivered by SiTCP
    typedef struct packed {
        logic                act;
        logic                we;
        logic                re;
        bus_pkg::bus_addr_t  addr;
        bus_pkg::bus_data_t  wd;
    } rbcp_req_t;

endpackage

/* source/bus_pkg.sv */
package bus_pkg;

    // Local byte bus
    typedef logic [31:0] bus_addr_t;
    typedef logic [7:0]  bus_data_t;

    // One bus cycle as seen by the slave
    typedef struct packed {
        logic      wr;
        logic      rd;
        bus_addr_t addr;
        bus_data_t wdata;
    } bus_req_t;

    // Register bank decodes this many bytes from address 0
    localparam int BANK_DEPTH  = 256;
    localparam int BANK_ADDR_W = $clog2(BANK_DEPTH);

endpackage
